// ==== design/ad9361_axis_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, lane counts and sample type for
// the ad9361 receive to axi-stream packing path
// converter samples are two's complement, 12 bits
//////////////////////////////////////////////////

`default_nettype none

package ad9361_axis_pkg;

  //////////////////////////////////////////////////
  // converter side

  // raw sample width out of the converter
  localparam int adc_width = 12;

  // one signed converter sample
  typedef logic signed [adc_width-1:0] adc_sample_t;

  //////////////////////////////////////////////////
  // stream side

  // samples emitted by one pair packer (two i, two q)
  localparam int lanes_per_pair_group = 4;

  // samples carried by one stream word
  localparam int lanes_per_word = 8;

  // full precision unless the top level asks for less
  localparam int default_precision = 12;

  // beats between tlast markers
  localparam int default_burst_length = 512;

endpackage

`default_nettype wire

// ==== design/ad9361_dual_axis.sv ====
//////////////////////////////////////////////////
// ad9361 style dual channel receive samples to one
// axi-stream word per sample period
// single clock, 2 cycles from any valid to tvalid
// a stalled beat is replaced by newer samples
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ad9361_dual_axis #(
  parameter int PRECISION         = ad9361_axis_pkg::default_precision,
  parameter int AXIS_BURST_LENGTH = ad9361_axis_pkg::default_burst_length
) (
  input  logic                                                 m_axis_clk,
  input  logic                                                 reset,

  // converter sample ports
  input  logic                                                 valid_0,
  input  ad9361_axis_pkg::adc_sample_t                         data_i0,
  input  ad9361_axis_pkg::adc_sample_t                         data_q0,
  input  logic                                                 valid_1,
  input  ad9361_axis_pkg::adc_sample_t                         data_i1,
  input  ad9361_axis_pkg::adc_sample_t                         data_q1,
  input  logic                                                 valid_2,
  input  ad9361_axis_pkg::adc_sample_t                         data_i2,
  input  ad9361_axis_pkg::adc_sample_t                         data_q2,
  input  logic                                                 valid_3,
  input  ad9361_axis_pkg::adc_sample_t                         data_i3,
  input  ad9361_axis_pkg::adc_sample_t                         data_q3,

  // axi-stream master
  input  logic                                                 m_axis_tready,
  output logic                                                 m_axis_tvalid,
  output logic [ad9361_axis_pkg::lanes_per_word*PRECISION-1:0] m_axis_tdata,
  output logic                                                 m_axis_tlast
);

  import ad9361_axis_pkg::*;

  localparam int half_width = lanes_per_pair_group * PRECISION;

  logic [half_width-1:0] hi_data;
  logic                  hi_strobe;
  logic [half_width-1:0] lo_data;
  logic                  lo_strobe;

  //////////////////////////////////////////////////
  // pair packers

  // pairs 0 and 1 fill the upper lanes
  iq_pair_packer #(
    .PRECISION   (PRECISION)
  ) u_pair_packer_hi (
    .m_axis_clk  (m_axis_clk),
    .reset       (reset),
    .valid_a     (valid_0),
    .i_a         (data_i0),
    .q_a         (data_q0),
    .valid_b     (valid_1),
    .i_b         (data_i1),
    .q_b         (data_q1),
    .half_data   (hi_data),
    .half_strobe (hi_strobe)
  );

  // pairs 2 and 3 fill the lower lanes
  iq_pair_packer #(
    .PRECISION   (PRECISION)
  ) u_pair_packer_lo (
    .m_axis_clk  (m_axis_clk),
    .reset       (reset),
    .valid_a     (valid_2),
    .i_a         (data_i2),
    .q_a         (data_q2),
    .valid_b     (valid_3),
    .i_b         (data_i3),
    .q_b         (data_q3),
    .half_data   (lo_data),
    .half_strobe (lo_strobe)
  );

  //////////////////////////////////////////////////
  // stream framing

  axis_burst_framer #(
    .PRECISION         (PRECISION),
    .AXIS_BURST_LENGTH (AXIS_BURST_LENGTH)
  ) u_burst_framer (
    .m_axis_clk        (m_axis_clk),
    .reset             (reset),
    .hi_data           (hi_data),
    .hi_strobe         (hi_strobe),
    .lo_data           (lo_data),
    .lo_strobe         (lo_strobe),
    .m_axis_tready     (m_axis_tready),
    .m_axis_tvalid     (m_axis_tvalid),
    .m_axis_tdata      (m_axis_tdata),
    .m_axis_tlast      (m_axis_tlast)
  );

endmodule

`default_nettype wire

// ==== design/axis_burst_framer.sv ====
//////////////////////////////////////////////////
// joins two packed half words into an axi-stream
// word and drives the tvalid/tready handshake
// a new strobe overwrites a stalled beat, no FIFO
// tlast every AXIS_BURST_LENGTH accepted beats (>= 2)
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module axis_burst_framer #(
  parameter int PRECISION         = ad9361_axis_pkg::default_precision,
  parameter int AXIS_BURST_LENGTH = ad9361_axis_pkg::default_burst_length
) (
  input  logic                                                   m_axis_clk,
  input  logic                                                   reset,
  input  logic [ad9361_axis_pkg::lanes_per_pair_group*PRECISION-1:0] hi_data,
  input  logic                                                   hi_strobe,
  input  logic [ad9361_axis_pkg::lanes_per_pair_group*PRECISION-1:0] lo_data,
  input  logic                                                   lo_strobe,
  input  logic                                                   m_axis_tready,
  output logic                                                   m_axis_tvalid,
  output logic [ad9361_axis_pkg::lanes_per_word*PRECISION-1:0]   m_axis_tdata,
  output logic                                                   m_axis_tlast
);

  import ad9361_axis_pkg::*;

  //////////////////////////////////////////////////
  // derived sizes

  // counter only has to reach AXIS_BURST_LENGTH-1
  localparam int count_width = (AXIS_BURST_LENGTH > 2) ? $clog2(AXIS_BURST_LENGTH) : 1;

  localparam logic [count_width-1:0] last_count = count_width'(AXIS_BURST_LENGTH - 1);

  if (AXIS_BURST_LENGTH < 2) begin : g_bad_burst
    $error("axis_burst_framer AXIS_BURST_LENGTH must be 2 or more");
  end

  logic                   load;
  logic                   beat_accepted;
  logic                   end_burst;
  logic [count_width-1:0] beat_count;

  // either packer produced a fresh half
  assign load = hi_strobe | lo_strobe;

  assign beat_accepted = m_axis_tvalid & m_axis_tready;

  //////////////////////////////////////////////////
  // data word

  // hi half sits in the upper lanes
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      m_axis_tdata <= '0;
    end else if (load) begin
      m_axis_tdata <= {hi_data, lo_data};
    end
  end

  //////////////////////////////////////////////////
  // valid handshake

  // new data wins, then hold while stalled, else drop
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      m_axis_tvalid <= 1'b0;
    end else if (load) begin
      m_axis_tvalid <= 1'b1;
    end else if (m_axis_tvalid && !m_axis_tready) begin
      m_axis_tvalid <= 1'b1;
    end else begin
      m_axis_tvalid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // burst counter and tlast

  assign end_burst = (beat_count == last_count);

  // moves only on accepted beats
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      beat_count <= '0;
    end else if (beat_accepted) begin
      if (end_burst) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  // marks the beat currently offered as the last of a burst
  assign m_axis_tlast = m_axis_tvalid & end_burst;

endmodule

`default_nettype wire

// ==== design/iq_pair_packer.sv ====
//////////////////////////////////////////////////
// captures two i/q pairs whenever either strobe is
// high and packs them into one half stream word
// lanes are truncated to the top PRECISION bits, no
// rounding, PRECISION must be 1 to 12
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module iq_pair_packer #(
  parameter int PRECISION = ad9361_axis_pkg::default_precision
) (
  input  logic                                                   m_axis_clk,
  input  logic                                                   reset,
  input  logic                                                   valid_a,
  input  ad9361_axis_pkg::adc_sample_t                           i_a,
  input  ad9361_axis_pkg::adc_sample_t                           q_a,
  input  logic                                                   valid_b,
  input  ad9361_axis_pkg::adc_sample_t                           i_b,
  input  ad9361_axis_pkg::adc_sample_t                           q_b,
  output logic [ad9361_axis_pkg::lanes_per_pair_group*PRECISION-1:0] half_data,
  output logic                                                   half_strobe
);

  import ad9361_axis_pkg::*;

  //////////////////////////////////////////////////
  // derived sizes

  localparam int half_width = lanes_per_pair_group * PRECISION;

  // bits dropped from each sample
  localparam int reduce_bits = adc_width - PRECISION;

  // catch a bad precision at elaboration
  if (PRECISION < 1 || PRECISION > adc_width) begin : g_bad_precision
    $error("iq_pair_packer PRECISION out of range");
  end

  //////////////////////////////////////////////////
  // lane ordering and precision reduction

  adc_sample_t           lane_in      [lanes_per_pair_group];
  adc_sample_t           lane_reduced [lanes_per_pair_group];
  logic [half_width-1:0] packed_next;
  logic                  capture;

  // lowest lane first, pair b below pair a
  assign lane_in[0] = q_b;
  assign lane_in[1] = i_b;
  assign lane_in[2] = q_a;
  assign lane_in[3] = i_a;

  genvar lane;
  for (lane = 0; lane < lanes_per_pair_group; lane++) begin : g_lane
    // arithmetic shift keeps the sign of each sample
    assign lane_reduced[lane] = lane_in[lane] >>> reduce_bits;

    assign packed_next[lane*PRECISION +: PRECISION] = lane_reduced[lane][PRECISION-1:0];
  end

  // both pairs are taken on either strobe
  assign capture = valid_a | valid_b;

  //////////////////////////////////////////////////
  // capture registers

  // last captured half word, held between strobes
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      half_data <= '0;
    end else if (capture) begin
      half_data <= packed_next;
    end
  end

  // one cycle pulse, aligned with the new half_data
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      half_strobe <= 1'b0;
    end else begin
      half_strobe <= capture;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/ad9361_axis_pkg.sv
design/iq_pair_packer.sv
design/axis_burst_framer.sv
design/ad9361_dual_axis.sv
sim/ad9361_dual_axis_assertions.sv
sim/tb_ad9361_dual_axis.sv

// ==== sim/ad9361_dual_axis_assertions.sv ====
//////////////////////////////////////////////////
// axi-stream protocol checks, bound into the top
// the latency check assumes no valid during reset
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ad9361_dual_axis_assertions (
  input logic m_axis_clk,
  input logic reset,
  input logic valid_0,
  input logic valid_1,
  input logic valid_2,
  input logic valid_3,
  input logic m_axis_tvalid,
  input logic m_axis_tready,
  input logic m_axis_tlast
);

  // read by the testbench summary
  int assertion_failures = 0;

  logic any_valid;

  assign any_valid = valid_0 | valid_1 | valid_2 | valid_3;

  a_tlast_with_tvalid: assert property (
    @(posedge m_axis_clk) disable iff (reset) m_axis_tlast |-> m_axis_tvalid
  ) else begin
    $error("tlast high while tvalid is low");
    assertion_failures++;
  end

  // a stalled beat must stay offered
  a_hold_under_stall: assert property (
    @(posedge m_axis_clk) disable iff (reset)
      (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid
  ) else begin
    $error("tvalid dropped while tready was low");
    assertion_failures++;
  end

  a_valid_latency: assert property (
    @(posedge m_axis_clk) disable iff (reset) any_valid |-> ##2 m_axis_tvalid
  ) else begin
    $error("tvalid not high two cycles after a sample valid");
    assertion_failures++;
  end

endmodule

bind ad9361_dual_axis ad9361_dual_axis_assertions u_assertions (.*);

`default_nettype wire

// ==== sim/tb_ad9361_dual_axis.sv ====
//////////////////////////////////////////////////
// self checking testbench for the dual axi top
// built with PRECISION 10 and burst length 8
// expects a single reset at the start of the run
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_ad9361_dual_axis;

  import ad9361_axis_pkg::*;

  localparam int precision      = 10;
  localparam int burst_length   = 8;
  localparam int word_width     = lanes_per_word * precision;
  localparam int drain_limit    = 60;
  // about 300 cycles of tests, the rest is margin
  localparam int timeout_cycles = 4000;
  localparam logic [31:0] rand_seed = 32'h2b5dddf8;

  logic m_axis_clk;
  logic reset;
  logic valid_0;
  logic valid_1;
  logic valid_2;
  logic valid_3;
  adc_sample_t data_i0;
  adc_sample_t data_q0;
  adc_sample_t data_i1;
  adc_sample_t data_q1;
  adc_sample_t data_i2;
  adc_sample_t data_q2;
  adc_sample_t data_i3;
  adc_sample_t data_q3;
  logic m_axis_tready;
  logic m_axis_tvalid;
  logic [word_width-1:0] m_axis_tdata;
  logic m_axis_tlast;

  // reference state
  adc_sample_t model_i [4];
  adc_sample_t model_q [4];
  logic [word_width-1:0] exp_q [$];
  logic pipe1_valid = 1'b0;
  logic pipe2_valid = 1'b0;
  logic [word_width-1:0] pipe1_word;
  logic [word_width-1:0] pipe2_word;
  logic [word_width-1:0] want_word;
  logic want_last;
  int beats_seen = 0;
  int lasts_seen = 0;
  int error_count = 0;
  int test_count = 0;
  int cycle_count = 0;

  ad9361_dual_axis #(
    .PRECISION         (precision),
    .AXIS_BURST_LENGTH (burst_length)
  ) u_dut (
    .m_axis_clk    (m_axis_clk),
    .reset         (reset),
    .valid_0       (valid_0),
    .data_i0       (data_i0),
    .data_q0       (data_q0),
    .valid_1       (valid_1),
    .data_i1       (data_i1),
    .data_q1       (data_q1),
    .valid_2       (valid_2),
    .data_i2       (data_i2),
    .data_q2       (data_q2),
    .valid_3       (valid_3),
    .data_i3       (data_i3),
    .data_q3       (data_q3),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
  );

  initial begin
    m_axis_clk = 1'b0;
    forever #50 m_axis_clk = ~m_axis_clk;
  end

  //////////////////////////////////////////////////
  // reference model

  // pair p sits in lanes 2*(3-p) (q) and 2*(3-p)+1 (i), top bits only
  function automatic logic [word_width-1:0] expected_word();
    logic [word_width-1:0] w;
    w = '0;
    for (int p = 0; p < 4; p++) begin
      w[(2 * (3 - p)) * precision +: precision]     = model_q[p][adc_width-1 -: precision];
      w[(2 * (3 - p) + 1) * precision +: precision] = model_i[p][adc_width-1 -: precision];
    end
    return w;
  endfunction

  function automatic logic drained();
    return exp_q.size() == 0 && !pipe1_valid && !pipe2_valid && !m_axis_tvalid;
  endfunction

  //////////////////////////////////////////////////
  // comparison on every rising edge

  always @(posedge m_axis_clk) begin
    if (reset) begin
      exp_q.delete();
      pipe1_valid = 1'b0;
      pipe2_valid = 1'b0;
      for (int p = 0; p < 4; p++) begin
        model_i[p] = '0;
        model_q[p] = '0;
      end
    end else begin
      // word from the valid two edges back, replaces one never taken
      if (pipe2_valid) begin
        if (exp_q.size() > 0) begin
          exp_q[exp_q.size() - 1] = pipe2_word;
        end else begin
          exp_q.push_back(pipe2_word);
        end
      end
      if (m_axis_tvalid && exp_q.size() == 0) begin
        $display("ERROR tvalid high with no sample pending at %0t", $time);
        error_count++;
      end
      if (!m_axis_tvalid && exp_q.size() != 0) begin
        $display("ERROR beat missing, tvalid low while a word is owed at %0t", $time);
        error_count++;
        exp_q.delete();
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_q.size() != 0) begin
          want_word = exp_q.pop_front();
          if (m_axis_tdata !== want_word) begin
            $display("MISMATCH m_axis_tdata got %h expected %h", m_axis_tdata, want_word);
            error_count++;
          end
        end
        want_last = (beats_seen % burst_length) == burst_length - 1;
        if (m_axis_tlast !== want_last) begin
          $display("MISMATCH m_axis_tlast got %h expected %h", m_axis_tlast, want_last);
          error_count++;
        end
        if (m_axis_tlast) begin
          lasts_seen++;
        end
        beats_seen++;
      end
      pipe2_valid = pipe1_valid;
      pipe2_word  = pipe1_word;
      // either valid captures the whole pair group
      if (valid_0 || valid_1) begin
        model_i[0] = data_i0;
        model_q[0] = data_q0;
        model_i[1] = data_i1;
        model_q[1] = data_q1;
      end
      if (valid_2 || valid_3) begin
        model_i[2] = data_i2;
        model_q[2] = data_q2;
        model_i[3] = data_i3;
        model_q[3] = data_q3;
      end
      pipe1_valid = valid_0 | valid_1 | valid_2 | valid_3;
      if (pipe1_valid) begin
        pipe1_word = expected_word();
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < timeout_cycles) begin
      @(posedge m_axis_clk);
      cycle_count++;
    end
    $display("ERROR timeout, run still going after %0d cycles", timeout_cycles);
    $display(">>> FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus helpers

  function automatic adc_sample_t random_sample();
    logic [31:0] r;
    r = $urandom();
    return r[adc_width-1:0];
  endfunction

  task automatic clear_valids();
    valid_0 = 1'b0;
    valid_1 = 1'b0;
    valid_2 = 1'b0;
    valid_3 = 1'b0;
  endtask

  // new data on every port, valids from the mask
  task automatic drive_sample(input logic [3:0] vmask);
    @(negedge m_axis_clk);
    data_i0 = random_sample();
    data_q0 = random_sample();
    data_i1 = random_sample();
    data_q1 = random_sample();
    data_i2 = random_sample();
    data_q2 = random_sample();
    data_i3 = random_sample();
    data_q3 = random_sample();
    {valid_3, valid_2, valid_1, valid_0} = vmask;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge m_axis_clk);
      clear_valids();
    end
  endtask

  task automatic wait_for_tvalid();
    int n;
    n = 0;
    do begin
      @(negedge m_axis_clk);
      clear_valids();
      n++;
    end while (!m_axis_tvalid && n < 10);
    if (!m_axis_tvalid) begin
      $display("ERROR tvalid never rose after a sample");
      error_count++;
    end
  endtask

  task automatic wait_drain(input bit random_ready);
    int n;
    logic [31:0] r;
    n = 0;
    do begin
      @(negedge m_axis_clk);
      clear_valids();
      if (random_ready) begin
        r = $urandom();
        m_axis_tready = r[0];
      end
      n++;
    end while (!drained() && n < drain_limit);
    if (!drained()) begin
      $display("ERROR stream did not drain in %0d cycles, tvalid stuck", drain_limit);
      error_count++;
    end
  endtask

  task automatic check_idle_outputs();
    if (m_axis_tvalid !== 1'b0) begin
      $display("MISMATCH m_axis_tvalid got %h expected 0", m_axis_tvalid);
      error_count++;
    end
    if (m_axis_tlast !== 1'b0) begin
      $display("MISMATCH m_axis_tlast got %h expected 0", m_axis_tlast);
      error_count++;
    end
    if (m_axis_tdata !== '0) begin
      $display("MISMATCH m_axis_tdata got %h expected %h", m_axis_tdata, {word_width{1'b0}});
      error_count++;
    end
  endtask

  task automatic check_beats(input int got, input int want);
    if (got != want) begin
      $display("ERROR expected %0d accepted beats, saw %0d", want, got);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin : stimulus
    int unsigned seed_discard;
    int errors_before;
    int beats_before;
    int lasts_before;
    int total_errors;
    logic [31:0] r;
    logic [3:0] vmask;
    logic [word_width-1:0] held_data;

    seed_discard = $urandom(rand_seed);
    reset = 1'b1;
    m_axis_tready = 1'b0;
    clear_valids();
    data_i0 = '0;
    data_q0 = '0;
    data_i1 = '0;
    data_q1 = '0;
    data_i2 = '0;
    data_q2 = '0;
    data_i3 = '0;
    data_q3 = '0;

    // reset state
    errors_before = error_count;
    repeat (2) begin
      @(negedge m_axis_clk);
      check_idle_outputs();
    end
    reset = 1'b0;
    m_axis_tready = 1'b1;
    @(negedge m_axis_clk);
    check_idle_outputs();
    report_test("reset state", errors_before);

    // back to back full words
    errors_before = error_count;
    beats_before = beats_seen;
    repeat (60) begin
      drive_sample(4'hf);
    end
    wait_drain(1'b0);
    check_beats(beats_seen - beats_before, 60);
    report_test("full words", errors_before);

    // one valid per group, the other half keeps its samples
    errors_before = error_count;
    beats_before = beats_seen;
    drive_sample(4'b0001);
    wait_drain(1'b0);
    drive_sample(4'b1000);
    wait_drain(1'b0);
    check_beats(beats_seen - beats_before, 2);
    report_test("partial capture", errors_before);

    // ten cycle stall with nothing new
    errors_before = error_count;
    beats_before = beats_seen;
    m_axis_tready = 1'b0;
    drive_sample(4'hf);
    wait_for_tvalid();
    held_data = m_axis_tdata;
    repeat (10) begin
      @(negedge m_axis_clk);
      if (m_axis_tvalid !== 1'b1) begin
        $display("MISMATCH m_axis_tvalid got %h expected 1", m_axis_tvalid);
        error_count++;
      end
      if (m_axis_tdata !== held_data) begin
        $display("MISMATCH m_axis_tdata got %h expected %h", m_axis_tdata, held_data);
        error_count++;
      end
    end
    m_axis_tready = 1'b1;
    wait_drain(1'b0);
    check_beats(beats_seen - beats_before, 1);
    report_test("back-pressure hold", errors_before);

    // second sample lands on a stalled beat
    errors_before = error_count;
    beats_before = beats_seen;
    m_axis_tready = 1'b0;
    drive_sample(4'hf);
    wait_for_tvalid();
    idle_cycles(2);
    drive_sample(4'hf);
    idle_cycles(4);
    m_axis_tready = 1'b1;
    wait_drain(1'b0);
    check_beats(beats_seen - beats_before, 1);
    report_test("overwrite under stall", errors_before);

    // random tready, one sample in flight at a time
    errors_before = error_count;
    beats_before = beats_seen;
    lasts_before = lasts_seen;
    if (beats_seen % burst_length != 0) begin
      $display("ERROR burst count not on a burst boundary before burst test");
      error_count++;
    end
    repeat (40) begin
      r = $urandom();
      vmask = (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
      drive_sample(vmask);
      wait_drain(1'b1);
    end
    m_axis_tready = 1'b1;
    check_beats(beats_seen - beats_before, 40);
    if (lasts_seen - lasts_before != 5) begin
      $display("ERROR expected 5 tlast beats, saw %0d", lasts_seen - lasts_before);
      error_count++;
    end
    report_test("burst marking", errors_before);

    total_errors = error_count + u_dut.u_assertions.assertion_failures;
    $display("summary: %0d tests, %0d beats, %0d errors, %0d assertion failures",
             test_count, beats_seen, error_count, u_dut.u_assertions.assertion_failures);
    if (total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
